//--- source/rtx_defines.svh
`ifndef RTX_DEFINES_SVH
`define RTX_DEFINES_SVH

// scene size
`define RTX_MAX_NUM_OBJS 16
`define RTX_OBJ_IDX_W 4
// one bit wider than the index so that a full scene of 16 fits
`define RTX_NUM_OBJS_W 5

// q12.4 constants
`define RTX_FP_ONE 16
// 640 in q12.4
`define RTX_FP_HALF_SCREEN_WIDTH 10240

// packet framing
`define RTX_SYNC_BYTE 8'hA5
// object write payload
`define RTX_OBJ_BYTES 4
// camera vector payload
`define RTX_VEC_BYTES 6

// uart bit period in clk_rtx cycles
`define RTX_CLKS_PER_BIT 16

`endif

//--- source/rtx_pkg.sv
`include "rtx_defines.svh"

package rtx_pkg;

  // one q12.4 component
  typedef logic [15:0] fp_t;

  // x in the top word, then y, then z
  typedef logic [3*16-1:0] vec3_t;

  // one scene object as the renderer reads it
  typedef logic [31:0] obj_word_t;

  typedef logic [`RTX_OBJ_IDX_W-1:0] obj_idx_t;
  typedef logic [`RTX_NUM_OBJS_W-1:0] num_objs_t;

  // 0 origin, 1 forward, 2 right, 3 up, 4 num_objs, 5 max_bounces
  typedef logic [2:0] cfg_sel_t;

  // payload bytes, right aligned
  typedef logic [47:0] flash_payload_t;

  typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_e;

  typedef enum logic [1:0] {fl_hunt, fl_cmd, fl_payload} flash_state_e;

  typedef enum logic [1:0] {walk_idle, walk_run, walk_drain} walk_state_e;

endpackage

//--- source/uart_receive.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module uart_receive #(
  parameter int clks_per_bit = `RTX_CLKS_PER_BIT
) (
  input  logic       clk_rtx,
  input  logic       sys_rst,
  input  logic       uart_rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  logic rxd_meta;
  logic rxd_sync;
  rtx_pkg::uart_state_e state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0] bit_cnt;
  // stop bit seen low, wait for idle line
  logic frame_err;

  // two flop synchronizer, idle high
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state     <= rtx_pkg::uart_idle;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
      frame_err <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        rtx_pkg::uart_idle: begin
          clk_cnt   <= '0;
          bit_cnt   <= '0;
          frame_err <= 1'b0;
          if (!rxd_sync) begin
            state <= rtx_pkg::uart_start;
          end
        end
        rtx_pkg::uart_start: begin
          // recheck at mid start bit, a glitch goes back to idle
          if (clk_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
            clk_cnt <= '0;
            state   <= rxd_sync ? rtx_pkg::uart_idle : rtx_pkg::uart_data;
          end
        end
        rtx_pkg::uart_data: begin
          if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            // lsb first
            rx_byte <= {rxd_sync, rx_byte[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rtx_pkg::uart_stop;
            end
          end
        end
        rtx_pkg::uart_stop: begin
          if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
            // hold here until the line returns high
            clk_cnt <= clk_cnt;
            if (rxd_sync) begin
              rx_valid <= !frame_err;
              state    <= rtx_pkg::uart_idle;
            end else begin
              frame_err <= 1'b1;
            end
          end
        end
        default: state <= rtx_pkg::uart_idle;
      endcase
    end
  end

  // downstream framing counts one byte per strobe
  a_rx_valid_pulse: assert property (
    @(posedge clk_rtx) disable iff (sys_rst) rx_valid |=> !rx_valid
  );

endmodule

//--- source/uart_memflash.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module uart_memflash (
  input  logic                    clk_rtx,
  input  logic                    sys_rst,
  input  logic                    rx_valid,
  input  logic [7:0]              rx_byte,
  output logic                    flash_active,
  output logic                    obj_wen,
  output rtx_pkg::obj_idx_t       obj_idx,
  output logic                    cfg_wen,
  output rtx_pkg::cfg_sel_t       cfg_sel,
  output rtx_pkg::flash_payload_t flash_payload
);

  localparam int pl_w = $bits(rtx_pkg::flash_payload_t);

  rtx_pkg::flash_state_e state;
  // payload bytes still to come
  logic [2:0] byte_cnt;
  logic is_obj;
  // index or selector in range
  logic tgt_ok;
  // strobe cycle, also for dropped packets
  logic pkt_done;

  // busy from the cycle after sync through the strobe cycle
  assign flash_active = (state != rtx_pkg::fl_hunt) || pkt_done;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state    <= rtx_pkg::fl_hunt;
      byte_cnt <= '0;
      is_obj   <= 1'b0;
      tgt_ok   <= 1'b0;
      pkt_done <= 1'b0;
      obj_wen  <= 1'b0;
      cfg_wen  <= 1'b0;
    end else begin
      pkt_done <= 1'b0;
      obj_wen  <= 1'b0;
      cfg_wen  <= 1'b0;
      case (state)
        rtx_pkg::fl_hunt: begin
          // junk bytes are thrown away
          if (rx_valid && rx_byte == `RTX_SYNC_BYTE) begin
            state <= rtx_pkg::fl_cmd;
          end
        end
        rtx_pkg::fl_cmd: begin
          if (rx_valid) begin
            state         <= rtx_pkg::fl_payload;
            flash_payload <= '0;
            is_obj        <= !rx_byte[7];
            obj_idx       <= rx_byte[`RTX_OBJ_IDX_W-1:0];
            cfg_sel       <= rx_byte[2:0];
            if (!rx_byte[7]) begin
              // object write, index in cmd[6:0]
              tgt_ok   <= rx_byte[6:0] < 7'(`RTX_MAX_NUM_OBJS);
              byte_cnt <= 3'(`RTX_OBJ_BYTES);
            end else begin
              // selectors 6 and 7 are consumed silently
              tgt_ok   <= rx_byte[2:0] <= 3'd5;
              byte_cnt <= rx_byte[2] ? 3'd1 : 3'(`RTX_VEC_BYTES);
            end
          end
        end
        rtx_pkg::fl_payload: begin
          if (rx_valid) begin
            // msb first, shifts up from the bottom
            flash_payload <= {flash_payload[pl_w-9:0], rx_byte};
            byte_cnt      <= byte_cnt - 1'b1;
            if (byte_cnt == 3'd1) begin
              state    <= rtx_pkg::fl_hunt;
              pkt_done <= 1'b1;
              obj_wen  <= is_obj && tgt_ok;
              cfg_wen  <= !is_obj && tgt_ok;
            end
          end
        end
        default: state <= rtx_pkg::fl_hunt;
      endcase
    end
  end

  // buffer and config never see the same packet
  a_one_target: assert property (
    @(posedge clk_rtx) disable iff (sys_rst) !(obj_wen && cfg_wen)
  );

endmodule

//--- source/scene_buffer.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module scene_buffer (
  input  logic                    clk_rtx,
  input  logic                    obj_wen,
  input  rtx_pkg::obj_idx_t       obj_idx,
  input  rtx_pkg::flash_payload_t flash_payload,
  input  rtx_pkg::obj_idx_t       rd_idx,
  output rtx_pkg::obj_word_t      rd_data
);

  // one word per object slot
  rtx_pkg::obj_word_t mem [`RTX_MAX_NUM_OBJS];

  // empty scene at configuration
  initial begin
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      mem[i] = '0;
    end
  end

  // flash write port
  always_ff @(posedge clk_rtx) begin
    if (obj_wen) begin
      // object sits in the low bytes of the payload
      mem[obj_idx] <= flash_payload[$bits(rtx_pkg::obj_word_t)-1:0];
    end
  end

  // registered read for the walker
  always_ff @(posedge clk_rtx) begin
    rd_data <= mem[rd_idx];
  end

endmodule

//--- source/scene_config.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module scene_config (
  input  logic                    clk_rtx,
  input  logic                    sys_rst,
  input  logic                    cfg_wen,
  input  rtx_pkg::cfg_sel_t       cfg_sel,
  input  logic                    obj_wen,
  input  rtx_pkg::flash_payload_t flash_payload,
  input  logic                    walk_done,
  input  logic                    force_overwrite,
  output rtx_pkg::vec3_t          cam_origin,
  output rtx_pkg::vec3_t          cam_forward,
  output rtx_pkg::vec3_t          cam_right,
  output rtx_pkg::vec3_t          cam_up,
  output rtx_pkg::num_objs_t      num_objs,
  output logic [7:0]              max_bounces,
  output logic                    render_overwrite
);

  localparam rtx_pkg::fp_t fp_zero = '0;
  localparam rtx_pkg::fp_t fp_one = `RTX_FP_ONE;
  localparam rtx_pkg::fp_t fp_half_w = `RTX_FP_HALF_SCREEN_WIDTH;

  // any accepted write since the last frame end
  logic scene_changed;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      // camera at the origin looking down +z
      cam_origin  <= '0;
      cam_forward <= {fp_zero, fp_zero, fp_half_w};
      cam_right   <= {fp_one, fp_zero, fp_zero};
      cam_up      <= {fp_zero, fp_one, fp_zero};
      num_objs    <= rtx_pkg::num_objs_t'(`RTX_MAX_NUM_OBJS);
      max_bounces <= 8'd3;
    end else if (cfg_wen) begin
      case (cfg_sel)
        3'd0: cam_origin  <= flash_payload;
        3'd1: cam_forward <= flash_payload;
        3'd2: cam_right   <= flash_payload;
        3'd3: cam_up      <= flash_payload;
        3'd4: begin
          // more than the buffer holds means all of it
          if (flash_payload[7:0] > 8'(`RTX_MAX_NUM_OBJS)) begin
            num_objs <= rtx_pkg::num_objs_t'(`RTX_MAX_NUM_OBJS);
          end else begin
            num_objs <= flash_payload[`RTX_NUM_OBJS_W-1:0];
          end
        end
        3'd5: max_bounces <= flash_payload[7:0];
        default: ;
      endcase
    end
  end

  // overwrite decision held for the whole next frame
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      scene_changed    <= 1'b0;
      render_overwrite <= 1'b0;
    end else if (walk_done) begin
      // a write landing on the frame end still counts
      render_overwrite <= force_overwrite || scene_changed || obj_wen || cfg_wen;
      scene_changed    <= 1'b0;
    end else if (obj_wen || cfg_wen) begin
      scene_changed <= 1'b1;
    end
  end

endmodule

//--- source/scene_walker.sv
`timescale 1ns/100ps

module scene_walker (
  input  logic                clk_rtx,
  input  logic                sys_rst,
  input  logic                frame_start,
  input  rtx_pkg::num_objs_t  num_objs,
  output rtx_pkg::obj_idx_t   rd_idx,
  input  rtx_pkg::obj_word_t  rd_data,
  output logic                obj_valid,
  output rtx_pkg::obj_idx_t   obj_idx_out,
  output rtx_pkg::obj_word_t  obj_data,
  output logic                walk_done
);

  rtx_pkg::walk_state_e walk_state;
  // index of the final object, taken at frame_start
  rtx_pkg::obj_idx_t last_idx;

  // buffer read is registered, so data lines up with the delayed valid
  assign obj_data = rd_data;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      walk_state  <= rtx_pkg::walk_idle;
      rd_idx      <= '0;
      last_idx    <= '0;
      obj_valid   <= 1'b0;
      obj_idx_out <= '0;
      walk_done   <= 1'b0;
    end else begin
      // valid and index ride one cycle behind rd_idx
      obj_valid   <= (walk_state == rtx_pkg::walk_run);
      obj_idx_out <= rd_idx;
      walk_done   <= (walk_state == rtx_pkg::walk_drain);
      case (walk_state)
        rtx_pkg::walk_idle: begin
          if (frame_start) begin
            rd_idx   <= '0;
            last_idx <= rtx_pkg::obj_idx_t'(num_objs - 1'b1);
            // empty scene skips straight to the end flag
            walk_state <= (num_objs == '0) ? rtx_pkg::walk_drain : rtx_pkg::walk_run;
          end
        end
        rtx_pkg::walk_run: begin
          if (rd_idx == last_idx) begin
            walk_state <= rtx_pkg::walk_drain;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
        // last read still in flight
        rtx_pkg::walk_drain: walk_state <= rtx_pkg::walk_idle;
        default: walk_state <= rtx_pkg::walk_idle;
      endcase
    end
  end

  a_no_valid_idle: assert property (
    @(posedge clk_rtx) disable iff (sys_rst)
      $rose(obj_valid) |-> (walk_state != rtx_pkg::walk_idle)
  );

endmodule

//--- source/scene_loader_top.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module scene_loader_top (
  input  logic                clk_rtx,
  input  logic                sys_rst,
  input  logic                uart_rxd,
  input  logic                frame_start,
  input  logic                force_overwrite,
  output logic                flash_active,
  output rtx_pkg::vec3_t      cam_origin,
  output rtx_pkg::vec3_t      cam_forward,
  output rtx_pkg::vec3_t      cam_right,
  output rtx_pkg::vec3_t      cam_up,
  output rtx_pkg::num_objs_t  num_objs,
  output logic [7:0]          max_bounces,
  output logic                render_overwrite,
  output logic                obj_valid,
  output rtx_pkg::obj_idx_t   obj_idx_out,
  output rtx_pkg::obj_word_t  obj_data,
  output logic                walk_done
);

  // uart bytes
  logic rx_valid;
  logic [7:0] rx_byte;

  // flash write strobes
  logic obj_wen;
  rtx_pkg::obj_idx_t obj_idx;
  logic cfg_wen;
  rtx_pkg::cfg_sel_t cfg_sel;
  rtx_pkg::flash_payload_t flash_payload;

  // walker read port
  rtx_pkg::obj_idx_t rd_idx;
  rtx_pkg::obj_word_t rd_data;

  uart_receive #(
    .clks_per_bit(`RTX_CLKS_PER_BIT)
  ) u_uart_receive (
    .clk_rtx  (clk_rtx),
    .sys_rst  (sys_rst),
    .uart_rxd (uart_rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  uart_memflash u_uart_memflash (
    .clk_rtx       (clk_rtx),
    .sys_rst       (sys_rst),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .flash_active  (flash_active),
    .obj_wen       (obj_wen),
    .obj_idx       (obj_idx),
    .cfg_wen       (cfg_wen),
    .cfg_sel       (cfg_sel),
    .flash_payload (flash_payload)
  );

  scene_buffer u_scene_buffer (
    .clk_rtx       (clk_rtx),
    .obj_wen       (obj_wen),
    .obj_idx       (obj_idx),
    .flash_payload (flash_payload),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  scene_config u_scene_config (
    .clk_rtx          (clk_rtx),
    .sys_rst          (sys_rst),
    .cfg_wen          (cfg_wen),
    .cfg_sel          (cfg_sel),
    .obj_wen          (obj_wen),
    .flash_payload    (flash_payload),
    .walk_done        (walk_done),
    .force_overwrite  (force_overwrite),
    .cam_origin       (cam_origin),
    .cam_forward      (cam_forward),
    .cam_right        (cam_right),
    .cam_up           (cam_up),
    .num_objs         (num_objs),
    .max_bounces      (max_bounces),
    .render_overwrite (render_overwrite)
  );

  // walk length follows the live object count
  scene_walker u_scene_walker (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .frame_start (frame_start),
    .num_objs    (num_objs),
    .rd_idx      (rd_idx),
    .rd_data     (rd_data),
    .obj_valid   (obj_valid),
    .obj_idx_out (obj_idx_out),
    .obj_data    (obj_data),
    .walk_done   (walk_done)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int period_ns = 20,
  parameter int rst_cycles = 16
) (
  output logic clk_rtx,
  output logic sys_rst
);

  // free running clock
  initial begin
    clk_rtx = 1'b0;
    forever #(period_ns / 2) clk_rtx = ~clk_rtx;
  end

  // reset released just after an edge, like the other drivers
  initial begin
    sys_rst = 1'b1;
    repeat (rst_cycles) @(posedge clk_rtx);
    #2 sys_rst = 1'b0;
  end

endmodule

//--- verif/scene_loader_tb.sv
`timescale 1ns/100ps
`include "rtx_defines.svh"

module scene_loader_tb;

  localparam int clk_period_ns = 20;
  localparam int bit_clks = `RTX_CLKS_PER_BIT;
  // bytes sent per test, sync and command included
  localparam int cfg_bytes = 2 + 4 * (2 + `RTX_VEC_BYTES) + 4 * 3;
  localparam int obj_bytes = 17 * (2 + `RTX_OBJ_BYTES);
  localparam int walk_bytes = 3 * 3;
  localparam int ovr_bytes = (2 + `RTX_OBJ_BYTES) + 3;
  localparam int stop_bytes = 4 + 3;
  localparam int total_bytes = cfg_bytes + obj_bytes + walk_bytes + ovr_bytes + stop_bytes;
  // 10 bits per byte, plus room for reset, frames and idle gaps
  localparam int watchdog_cycles = total_bytes * 10 * bit_clks + 4000;

  logic clk_rtx;
  logic sys_rst;
  logic uart_rxd;
  logic frame_start;
  logic force_overwrite;
  logic flash_active;
  rtx_pkg::vec3_t cam_origin;
  rtx_pkg::vec3_t cam_forward;
  rtx_pkg::vec3_t cam_right;
  rtx_pkg::vec3_t cam_up;
  rtx_pkg::num_objs_t num_objs;
  logic [7:0] max_bounces;
  logic render_overwrite;
  logic obj_valid;
  rtx_pkg::obj_idx_t obj_idx_out;
  rtx_pkg::obj_word_t obj_data;
  logic walk_done;

  // reference model of what the scene should hold
  rtx_pkg::vec3_t exp_cam [4];
  rtx_pkg::num_objs_t exp_num;
  logic [7:0] exp_bounces;
  rtx_pkg::obj_word_t exp_mem [`RTX_MAX_NUM_OBJS];

  int value_errors;
  int other_errors;
  // cycles with the decoder out of hunt
  int flash_cycles;

  tb_clock_gen #(
    .period_ns  (clk_period_ns),
    .rst_cycles (16)
  ) u_clock_gen (
    .clk_rtx (clk_rtx),
    .sys_rst (sys_rst)
  );

  scene_loader_top DUT (.*);

  always @(posedge clk_rtx) begin
    if (flash_active) begin
      flash_cycles++;
    end
  end

  // wait n edges, land 2 ns after the last one
  task automatic tick(input int n);
    repeat (n) @(posedge clk_rtx);
    #2;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    value_errors++;
    $display("FAIL %s expected %0h actual %0h", name, exp, act);
  endtask

  // 8N1, lsb first
  task automatic send_byte(input logic [7:0] b, input logic stop_bit);
    uart_rxd = 1'b0;
    tick(bit_clks);
    for (int i = 0; i < 8; i++) begin
      uart_rxd = b[i];
      tick(bit_clks);
    end
    uart_rxd = stop_bit;
    tick(bit_clks);
    // a broken stop bit needs an idle gap before the next start
    if (!stop_bit) begin
      uart_rxd = 1'b1;
      tick(bit_clks);
    end
  endtask

  // decoder goes back to hunt after the strobe cycle
  task automatic wait_flash_idle();
    int n;
    n = 0;
    while (flash_active && n < 4 * bit_clks) begin
      tick(1);
      n++;
    end
    if (flash_active) begin
      other_errors++;
      $display("decoder still busy %0d cycles after the last payload byte", n);
    end
    tick(1);
  endtask

  // payload goes out msb first
  task automatic send_packet(input logic [7:0] cmd, input rtx_pkg::flash_payload_t payload,
                             input int nbytes);
    int exp_busy;
    // busy from the cycle after the sync strobe through the write strobe cycle,
    // one byte period per byte after sync
    exp_busy = (nbytes + 1) * 10 * bit_clks + 1;
    flash_cycles = 0;
    send_byte(`RTX_SYNC_BYTE, 1'b1);
    send_byte(cmd, 1'b1);
    for (int i = nbytes - 1; i >= 0; i--) begin
      send_byte(payload[8*i +: 8], 1'b1);
    end
    wait_flash_idle();
    if (flash_cycles != exp_busy) begin
      report_mismatch("packet_flash_active", exp_busy, flash_cycles);
    end
  endtask

  task automatic check_config(input string name);
    if (cam_origin !== exp_cam[0]) report_mismatch({name, " origin"}, exp_cam[0], cam_origin);
    if (cam_forward !== exp_cam[1]) report_mismatch({name, " forward"}, exp_cam[1], cam_forward);
    if (cam_right !== exp_cam[2]) report_mismatch({name, " right"}, exp_cam[2], cam_right);
    if (cam_up !== exp_cam[3]) report_mismatch({name, " up"}, exp_cam[3], cam_up);
    if (num_objs !== exp_num) report_mismatch({name, " num_objs"}, exp_num, num_objs);
    if (max_bounces !== exp_bounces) begin
      report_mismatch({name, " max_bounces"}, exp_bounces, max_bounces);
    end
  endtask

  // first valid 2 cycles after frame_start, done the cycle after the last valid
  task automatic run_frame(input string name, input int n, input logic exp_ovr);
    logic exp_valid;
    frame_start = 1'b1;
    tick(1);
    for (int j = 1; j <= n + 4; j++) begin
      // second start while busy must be ignored
      frame_start = (j == 3 && n >= 3);
      exp_valid = (j >= 2) && (j <= n + 1);
      if (obj_valid !== exp_valid) report_mismatch({name, " obj_valid"}, exp_valid, obj_valid);
      if (exp_valid) begin
        if (obj_idx_out !== rtx_pkg::obj_idx_t'(j - 2)) begin
          report_mismatch({name, " obj_idx_out"}, j - 2, obj_idx_out);
        end
        if (obj_data !== exp_mem[j-2]) begin
          report_mismatch({name, " obj_data"}, exp_mem[j-2], obj_data);
        end
      end
      if (walk_done !== (j == n + 2)) report_mismatch({name, " walk_done"}, j == n + 2, walk_done);
      tick(1);
    end
    if (render_overwrite !== exp_ovr) begin
      report_mismatch({name, " render_overwrite"}, exp_ovr, render_overwrite);
    end
  endtask

  task automatic check_reset_defaults;
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      exp_mem[i] = '0;
    end
    exp_cam[0] = '0;
    exp_cam[1] = {16'd0, 16'd0, 16'(`RTX_FP_HALF_SCREEN_WIDTH)};
    exp_cam[2] = {16'(`RTX_FP_ONE), 16'd0, 16'd0};
    exp_cam[3] = {16'd0, 16'(`RTX_FP_ONE), 16'd0};
    exp_num = rtx_pkg::num_objs_t'(`RTX_MAX_NUM_OBJS);
    exp_bounces = 8'd3;
    check_config("reset_defaults");
    if (flash_active !== 1'b0) report_mismatch("reset_defaults flash_active", 0, flash_active);
    if (DUT.obj_wen !== 1'b0) report_mismatch("reset_defaults obj_wen", 0, DUT.obj_wen);
    if (DUT.cfg_wen !== 1'b0) report_mismatch("reset_defaults cfg_wen", 0, DUT.cfg_wen);
    if (obj_valid !== 1'b0) report_mismatch("reset_defaults obj_valid", 0, obj_valid);
    if (walk_done !== 1'b0) report_mismatch("reset_defaults walk_done", 0, walk_done);
    if (render_overwrite !== 1'b0) begin
      report_mismatch("reset_defaults render_overwrite", 0, render_overwrite);
    end
  endtask

  task automatic load_config_packets;
    rtx_pkg::vec3_t v;
    logic [7:0] b;
    // junk ahead of the first sync
    send_byte(8'h3c, 1'b1);
    send_byte(8'h00, 1'b1);
    for (int s = 0; s < 4; s++) begin
      v = {16'($urandom), 32'($urandom)};
      send_packet(8'h80 | 8'(s), v, `RTX_VEC_BYTES);
      exp_cam[s] = v;
      check_config("config_vector");
    end
    send_packet(8'h84, 48'd5, 1);
    exp_num = 5;
    check_config("config_num_objs");
    // bit 6 set keeps it away from the recovery value used later
    b = 8'($urandom) | 8'h40;
    send_packet(8'h85, 48'(b), 1);
    exp_bounces = b;
    check_config("config_bounces");
    // selector 6 is consumed with no effect
    send_packet(8'h86, 48'h77, 1);
    check_config("config_sel6");
    send_packet(8'h84, 48'd20, 1);
    exp_num = 16;
    check_config("config_clip");
  endtask

  task automatic stream_objects;
    rtx_pkg::obj_word_t w;
    for (int i = 0; i < `RTX_MAX_NUM_OBJS; i++) begin
      w = $urandom;
      send_packet(8'(i), 48'(w), `RTX_OBJ_BYTES);
      exp_mem[i] = w;
    end
    // index 40 aliases slot 8 if the range check were missing
    w = $urandom;
    send_packet(8'd40, 48'(w), `RTX_OBJ_BYTES);
    run_frame("object_stream", exp_num, 1'b1);
  endtask

  task automatic vary_walk_length;
    send_packet(8'h84, 48'd3, 1);
    exp_num = 3;
    run_frame("walk_3", 3, 1'b1);
    send_packet(8'h84, 48'd0, 1);
    exp_num = 0;
    run_frame("walk_0", 0, 1'b1);
    send_packet(8'h84, 48'd16, 1);
    exp_num = 16;
    run_frame("walk_16", 16, 1'b1);
  endtask

  task automatic track_overwrite;
    run_frame("quiet_frame", exp_num, 1'b0);
    force_overwrite = 1'b1;
    run_frame("forced_frame", exp_num, 1'b1);
    force_overwrite = 1'b0;
    // rejected packet is not an accepted one
    send_packet(8'd40, 48'h1234, `RTX_OBJ_BYTES);
    run_frame("rejected_frame", exp_num, 1'b0);
    send_packet(8'h86, 48'h01, 1);
    run_frame("sel6_frame", exp_num, 1'b0);
  endtask

  task automatic drop_bad_stop_bit;
    flash_cycles = 0;
    // sync lost, so command and payload are just junk to the hunter
    send_byte(`RTX_SYNC_BYTE, 1'b0);
    send_byte(8'h85, 1'b1);
    send_byte(8'h09, 1'b1);
    tick(bit_clks);
    if (flash_cycles != 0) begin
      other_errors++;
      $display("decoder left hunt on a sync byte with a zero stop bit");
    end
    check_config("bad_stop_dropped");
    // receiver recovers for the next clean packet
    send_packet(8'h85, 48'h09, 1);
    exp_bounces = 8'h09;
    check_config("bad_stop_recovery");
  endtask

  initial begin
    #(watchdog_cycles * clk_period_ns);
    $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    uart_rxd = 1'b1;
    frame_start = 1'b0;
    force_overwrite = 1'b0;
    value_errors = 0;
    other_errors = 0;
    flash_cycles = 0;
    void'($urandom(32'h12e8));
    wait (sys_rst === 1'b0);
    tick(2);
    check_reset_defaults();
    load_config_packets();
    stream_objects();
    vary_walk_length();
    track_overwrite();
    drop_bad_stop_bit();
    $display("value mismatches %0d, other failures %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/rtx_pkg.sv
source/uart_receive.sv
source/uart_memflash.sv
source/scene_buffer.sv
source/scene_config.sv
source/scene_walker.sv
source/scene_loader_top.sv
verif/tb_clock_gen.sv
verif/scene_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the scene loader testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module scene_loader_tb -o scene_loader_sim \
  && ./obj_dir/scene_loader_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
exit 0
